//--- verilog.f
src/sprite_pkg.sv
src/wb_cmd_port.sv
src/instr_decoder.sv
src/sprite_slot.sv
src/sprite_hit_select.sv
src/sprite_color_mem.sv
src/sprite_cmd_top.sv
test/sprite_checker.sv
test/tb_sprite_cmd.sv

//--- test/tb_sprite_cmd.sv
// testbench for the sprite command front end
// clock, reset, lfsr, stimulus table, wishbone master tasks and watchdog
`timescale 1ns/1ps
`default_nettype none

module tb_sprite_cmd;

	typedef struct packed {
		logic        rd;    // 1 read, 0 write
		logic [2:0]  adr;
		logic [31:0] data;
	} step_t;

	logic        clk_en;
	logic        reset;
	logic        cyc;
	logic        stb;
	logic        we;
	logic [4:2]  adr;
	logic [31:0] dat_i;
	logic [31:0] dat_o;
	logic        ack;
	step_t       steps[$];   // stimulus table
	logic [31:0] lfsr;
	int          bus_errors;
	int          chk_errors;
	int          chk_reads;
	int          wd_cycles;
	int          k;
	bit          table_ready;

	sprite_cmd_top uut (.clk_en, .reset, .cyc, .stb, .we, .adr, .dat_i, .dat_o, .ack);

	sprite_checker #(.N_SPRITES(8), .SPRITE_SIZE(20), .MEM_AW(8)) u_check (
		.clk_en, .reset, .cyc, .stb, .we, .adr, .dat_i, .dat_o, .ack,
		.errors (chk_errors),
		.reads  (chk_reads)
	);

	initial begin
		clk_en = 1'b0;
		forever #2 clk_en = ~clk_en;  // 4 ns period
	end

	// fibonacci lfsr x^32+x^22+x^2+x+1
	function automatic logic [31:0] rand_bits(input int n);
		logic [31:0] r;
		int          i;
		r = '0;
		for (i = 0; i < n; i++) begin
			lfsr = {lfsr[30:0], lfsr[31] ^ lfsr[21] ^ lfsr[1] ^ lfsr[0]};
			r    = {r[30:0], lfsr[0]};  // one step per bit
		end
		return r;
	endfunction

	////////////////////////////////////////////////////////////
	// table building
	////////////////////////////////////////////////////////////

	function automatic void wr(input logic [2:0] a, input logic [31:0] d);
		steps.push_back({1'b0, a, d});
	endfunction

	function automatic void rd(input logic [2:0] a);
		steps.push_back({1'b1, a, 32'd0});
	endfunction

	// slot number is the low 5 bits of the register field
	function automatic void instr(input logic [3:0] op, input logic [13:0] f, input logic [31:0] b);
		wr(3'd0, {14'd0, f, op});
		wr(3'd1, b);
	endfunction

	function automatic void query(input int x, input int y);
		wr(3'd2, {12'd0, x[9:0], y[9:0]});
		rd(3'd2);
	endfunction

	function automatic void set_pos(input int s, input int x, input int y, input bit en);
		instr(4'd0, s[13:0], {2'b00, en, 9'd0, x[9:0], y[9:0]});
	endfunction

	function automatic void mem_read(input logic [13:0] a);
		wr(3'd4, {18'd0, a});
		rd(3'd4);
	endfunction

	task automatic build_table();
		logic [13:0] a;
		int          i;
		rd(3'd2);                         // no hit out of reset
		rd(3'd3);                         // count starts at zero
		rd(3'd0);
		rd(3'd7);
		set_pos(0, 100, 50, 1);
		query(100, 50);                   // top left pixel
		query(119, 69);                   // bottom right pixel
		query(120, 60);                   // one past right edge
		query(110, 70);                   // one past bottom edge
		query(99, 60);
		instr(4'd2, 14'd0, 32'h1a5);
		set_pos(3, 110, 60, 1);
		instr(4'd2, 14'd3, 32'h033);
		set_pos(5, 105, 55, 1);
		instr(4'd2, 14'd5, 32'h0f0);
		query(112, 62);                   // 0, 3 and 5 overlap
		query(125, 62);                   // only 3
		set_pos(0, 100, 50, 0);
		query(112, 62);
		set_pos(3, 110, 60, 0);
		query(112, 62);
		set_pos(2, 1010, 1010, 1);
		query(1023, 1023);                // coordinate limit
		for (i = 0; i < 5; i++) begin
			a = rand_bits(14);
			instr(4'd1, a, rand_bits(32));
			mem_read(a);
			mem_read(a ^ 14'h3f00);        // same low bits
		end
		instr(4'd1, 14'h005, rand_bits(32));
		instr(4'd1, 14'h105, rand_bits(32));  // lands on word 5
		mem_read(14'h005);
		for (i = 4; i < 16; i++) begin
			instr(i[3:0], 14'h005, rand_bits(32) | 32'h2000_0000);
			rd(3'd3);
		end
		instr(4'd3, 14'h005, rand_bits(32) | 32'h2000_0000);
		rd(3'd3);
		mem_read(14'h005);
		query(112, 62);                   // slot 5 untouched
		set_pos(1, 200, 200, 1);
		set_pos(8, 300, 300, 1);          // past the slot array
		set_pos(31, 300, 300, 1);
		instr(4'd2, 14'd9, 32'h1ff);
		query(305, 305);
		query(205, 205);                  // slot 1 offset still zero
	endtask

	////////////////////////////////////////////////////////////
	// wishbone master
	////////////////////////////////////////////////////////////

	// hold the request until ack, release, then two idle cycles
	task automatic hold_cycle();
		int n;
		n = 0;
		while (!ack && n < 32) begin
			@(posedge clk_en);
			#1;
			n++;
		end
		if (!ack) begin
			bus_errors++;
			$display("no ack from DUT for address %0d by %0d ns", adr, $time);
		end
		@(posedge clk_en);
		#1;
		cyc   = 1'b0;
		stb   = 1'b0;
		we    = 1'b0;
		adr   = 3'd0;
		dat_i = 32'd0;
		repeat (2) @(posedge clk_en);
		#1;
	endtask

	task automatic wb_write(input logic [2:0] a, input logic [31:0] d);
		cyc   = 1'b1;
		stb   = 1'b1;
		we    = 1'b1;
		adr   = a;
		dat_i = d;
		hold_cycle();
	endtask

	task automatic wb_read(input logic [2:0] a);
		cyc = 1'b1;
		stb = 1'b1;
		we  = 1'b0;
		adr = a;
		hold_cycle();
	endtask

	initial begin
		lfsr       = 32'he523;
		reset      = 1'b1;
		cyc        = 1'b0;
		stb        = 1'b0;
		we         = 1'b0;
		adr        = 3'd0;
		dat_i      = 32'd0;
		bus_errors = 0;
		build_table();
		table_ready = 1'b1;
		repeat (16) @(posedge clk_en);
		#1 reset = 1'b0;
		repeat (2) @(posedge clk_en);
		#1;
		for (k = 0; k < steps.size(); k++) begin
			if (steps[k].rd)
				wb_read(steps[k].adr);
			else
				wb_write(steps[k].adr, steps[k].data);
		end
		repeat (4) @(posedge clk_en);
		$display("errors: %0d checker, %0d bus, %0d reads compared",
			chk_errors, bus_errors, chk_reads);
		if (chk_errors == 0 && bus_errors == 0 && chk_reads > 0) begin
			$display("TB PASSED");
		end else begin
			$display("TB FAILED");
		end
		$finish;
	end

	// bound scales with the table length
	initial begin
		wait (table_ready);
		wd_cycles = steps.size() * 20 + 200;
		repeat (wd_cycles) @(posedge clk_en);
		$display("watchdog expired after %0d cycles, the run did not finish", wd_cycles);
		$display("TB FAILED");
		$finish;
	end

endmodule

`default_nettype wire

//--- test/sprite_checker.sv
// bus watching checker for the sprite command front end
// reference model of slots, colour memory and invalid count
`timescale 1ns/1ps
`default_nettype none

module sprite_checker #(
	parameter int N_SPRITES   = 8,
	parameter int SPRITE_SIZE = 20,
	parameter int MEM_AW      = 8
) (
	input  logic        clk_en,
	input  logic        reset,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [4:2]  adr,
	input  logic [31:0] dat_i,
	input  logic [31:0] dat_o,
	input  logic        ack,
	output int          errors,
	output int          reads
);

	int          sx     [N_SPRITES];  // left edge per slot
	int          sy     [N_SPRITES];  // top edge
	bit          sen    [N_SPRITES];
	logic [8:0]  soff   [N_SPRITES];
	logic [31:0] mem    [2**MEM_AW];  // colour words seen written
	bit          mvalid [2**MEM_AW];
	logic [31:0] word_a;
	logic [15:0] count;               // invalid instructions, saturating
	int          qx;
	int          qy;
	int          raddr;               // already folded to MEM_AW bits

	initial begin
		errors = 0;
		reads  = 0;
	end

	////////////////////////////////////////////////////////////
	// model update on an issue write
	////////////////////////////////////////////////////////////

	function automatic void apply_instr(input logic [31:0] b);
		int slot;
		int maddr;
		slot  = word_a[8:4];
		maddr = word_a[17:4] % (2**MEM_AW);  // high address bits alias
		case (word_a[3:0])
			4'd0: if (slot < N_SPRITES) begin
				sx[slot]  = b[19:10];
				sy[slot]  = b[9:0];
				sen[slot] = b[29];
			end
			4'd1: begin
				mem[maddr]    = b;
				mvalid[maddr] = 1'b1;
			end
			4'd2: if (slot < N_SPRITES) soff[slot] = b[8:0];
			4'd3: ;  // no-op, not counted
			default: if (count != 16'hffff) count = count + 16'd1;
		endcase
	endfunction

	// lowest enabled slot whose square holds the query pixel
	function automatic logic [31:0] query_result();
		logic [31:0] r;
		bit          found;
		int          i;
		r     = 32'd0;
		found = 1'b0;
		for (i = 0; i < N_SPRITES; i++) begin
			if (!found && sen[i] && qx >= sx[i] && qx < sx[i] + SPRITE_SIZE
					&& qy >= sy[i] && qy < sy[i] + SPRITE_SIZE) begin
				found     = 1'b1;
				r[31]     = 1'b1;
				r[20:16]  = i[4:0];
				r[8:0]    = soff[i];
			end
		end
		return r;
	endfunction

	task automatic check_read();
		logic [31:0] want;
		bit          known;
		known = 1'b1;
		case (adr)
			3'd2: want = query_result();
			3'd3: want = {16'd0, count};
			3'd4: begin
				want  = mem[raddr];
				known = mvalid[raddr];
			end
			default: want = 32'd0;  // write-only and unmapped words
		endcase
		reads++;
		if (!known) begin
			errors++;
			$display("colour word %0d was read before any write, at %0d ns", raddr, $time);
		end else if (dat_o !== want) begin
			errors++;
			$display("FAIL %0d ns: read of address %0d gave %08h, expected %08h",
				$time, adr, dat_o, want);
		end
	endtask

	////////////////////////////////////////////////////////////
	// bus monitor, one look per completed cycle
	////////////////////////////////////////////////////////////

	always @(posedge clk_en) begin
		if (reset) begin
			for (int i = 0; i < N_SPRITES; i++) begin
				sx[i]   = 0;
				sy[i]   = 0;
				sen[i]  = 1'b0;
				soff[i] = 9'd0;
			end
			count = 16'd0;
		end else if (cyc && stb && ack) begin
			if (we) begin
				case (adr)
					3'd0: word_a = dat_i;
					3'd1: apply_instr(dat_i);
					3'd2: begin
						qx = dat_i[19:10];  // query pixel
						qy = dat_i[9:0];
					end
					3'd4: raddr = dat_i[13:0] % (2**MEM_AW);
					default: ;
				endcase
			end else begin
				check_read();
			end
		end
	end

endmodule

`default_nettype wire

//--- src/sprite_cmd_top.sv
// sprite command front end top level
// bus port, decoder, slot array, hit selector and colour memory
`timescale 1ns/1ps
`default_nettype none

module sprite_cmd_top #(
	parameter int N_SPRITES   = 8,
	parameter int SPRITE_SIZE = 20,
	parameter int MEM_AW      = 8
) (
	input  logic        clk_en,
	input  logic        reset,
	input  logic        cyc,
	input  logic        stb,
	input  logic        we,
	input  logic [4:2]  adr,
	input  logic [31:0] dat_i,
	output logic [31:0] dat_o,
	output logic        ack
);
	import sprite_pkg::*;

	logic                         instr_valid;
	logic [31:0]                  word_a;
	logic [31:0]                  word_b;
	logic                         dec_valid;
	op_t                          dec_opcode;
	logic [REG_W-1:0]             dec_register;
	logic [31:0]                  dec_data;
	logic [COORD_W-1:0]           query_x;
	logic [COORD_W-1:0]           query_y;
	logic [REG_W-1:0]             mem_raddr;
	logic [31:0]                  mem_rdata;
	logic                         mem_we;
	logic [N_SPRITES-1:0]         covers;
	logic [N_SPRITES*OFFSET_W-1:0] offsets;  // slot i at i*OFFSET_W
	logic                         hit;
	logic [SLOT_W-1:0]            hit_slot;
	logic [OFFSET_W-1:0]          hit_offset;

	assign mem_we = dec_valid && (dec_opcode == op_mem_write);

	wb_cmd_port u_port (
		.clk_en, .reset, .cyc, .stb, .we, .adr, .dat_i, .dat_o, .ack,
		.hit, .hit_slot, .hit_offset, .mem_rdata, .dec_valid, .dec_opcode,
		.instr_valid, .word_a, .word_b, .query_x, .query_y, .mem_raddr
	);

	instr_decoder u_dec (
		.clk_en, .reset, .instr_valid, .word_a, .word_b,
		.dec_valid, .dec_opcode, .dec_register, .dec_data
	);

	////////////////////////////////////////////////////////////
	// slot array
	////////////////////////////////////////////////////////////

	for (genvar g = 0; g < N_SPRITES; g++) begin : g_slot
		sprite_slot #(.SLOT_ID(g), .SPRITE_SIZE(SPRITE_SIZE)) u_slot (
			.clk_en, .reset, .dec_valid, .dec_opcode, .dec_register, .dec_data,
			.query_x, .query_y,
			.covers (covers[g]),
			.offset (offsets[g*OFFSET_W +: OFFSET_W])
		);
	end

	sprite_hit_select #(.N_SPRITES(N_SPRITES)) u_sel (
		.clk_en, .reset, .covers, .offsets, .hit, .hit_slot, .hit_offset
	);

	// high address bits alias onto the low words
	sprite_color_mem #(.MEM_AW(MEM_AW)) u_mem (
		.clk_en,
		.we    (mem_we),
		.waddr (dec_register[MEM_AW-1:0]),
		.wdata (dec_data),
		.raddr (mem_raddr[MEM_AW-1:0]),
		.rdata (mem_rdata)
	);

endmodule

`default_nettype wire

//--- src/sprite_color_mem.sv
// sprite colour memory
// single clock, instruction write port and bus read port
`timescale 1ns/1ps
`default_nettype none

module sprite_color_mem #(
	parameter int MEM_AW = 8
) (
	input  logic              clk_en,
	input  logic              we,
	input  logic [MEM_AW-1:0] waddr,
	input  logic [31:0]       wdata,
	input  logic [MEM_AW-1:0] raddr,
	output logic [31:0]       rdata
);

	logic [31:0] mem [2**MEM_AW];  // colour words

	always_ff @(posedge clk_en) begin
		if (we) begin
			mem[waddr] <= wdata;
		end
	end

	// registered read, new data forwarded on a same-address write
	always_ff @(posedge clk_en) begin
		if (we && waddr == raddr) begin
			rdata <= wdata;
		end else begin
			rdata <= mem[raddr];
		end
	end

endmodule

`default_nettype wire

//--- src/sprite_hit_select.sv
// priority hit selector
// lowest covering slot wins, result registered with its offset
`timescale 1ns/1ps
`default_nettype none

module sprite_hit_select #(
	parameter int N_SPRITES = 8
) (
	input  logic                                      clk_en,
	input  logic                                      reset,
	input  logic [N_SPRITES-1:0]                      covers,
	input  logic [N_SPRITES*sprite_pkg::OFFSET_W-1:0] offsets,
	output logic                                      hit,
	output logic [sprite_pkg::SLOT_W-1:0]             hit_slot,
	output logic [sprite_pkg::OFFSET_W-1:0]           hit_offset
);
	import sprite_pkg::*;

	logic                nxt_hit;
	logic [SLOT_W-1:0]   nxt_slot;
	logic [OFFSET_W-1:0] nxt_offset;

	// walk down so the lowest index is the last one written
	always_comb begin
		nxt_hit    = 1'b0;
		nxt_slot   = '0;  // all zero when nothing covers
		nxt_offset = '0;
		for (int i = N_SPRITES - 1; i >= 0; i--) begin
			if (covers[i]) begin
				nxt_hit    = 1'b1;
				nxt_slot   = SLOT_W'(i);
				nxt_offset = offsets[i*OFFSET_W +: OFFSET_W];
			end
		end
	end

	always_ff @(posedge clk_en) begin
		if (reset) begin
			hit        <= 1'b0;
			hit_slot   <= '0;
			hit_offset <= '0;
		end else begin
			hit        <= nxt_hit;
			hit_slot   <= nxt_slot;
			hit_offset <= nxt_offset;
		end
	end

	a_slot_range: assert property (@(posedge clk_en) disable iff (reset)
		hit |-> (hit_slot < N_SPRITES))
		else $error("hit reported for slot %0d", hit_slot);

endmodule

`default_nettype wire

//--- src/sprite_slot.sv
// one sprite slot
// position, enable and offset registers plus the coverage test
`timescale 1ns/1ps
`default_nettype none

module sprite_slot #(
	parameter int SLOT_ID     = 0,
	parameter int SPRITE_SIZE = 20
) (
	input  logic                             clk_en,
	input  logic                             reset,
	input  logic                             dec_valid,
	input  sprite_pkg::op_t                  dec_opcode,
	input  logic [sprite_pkg::REG_W-1:0]     dec_register,
	input  logic [31:0]                      dec_data,
	input  logic [sprite_pkg::COORD_W-1:0]   query_x,
	input  logic [sprite_pkg::COORD_W-1:0]   query_y,
	output logic                             covers,
	output logic [sprite_pkg::OFFSET_W-1:0]  offset
);
	import sprite_pkg::*;

	logic [COORD_W-1:0] pos_x;   // left edge
	logic [COORD_W-1:0] pos_y;   // top edge
	logic               enable;
	logic               sel;     // instruction targets this slot
	logic [COORD_W:0]   x_end;   // one past right edge, no wrap
	logic [COORD_W:0]   y_end;
	logic               in_x;
	logic               in_y;

	assign sel = dec_valid && (dec_register == REG_W'(SLOT_ID));

	always_ff @(posedge clk_en) begin
		if (reset) begin
			pos_x  <= '0;
			pos_y  <= '0;
			enable <= 1'b0;
			offset <= '0;
		end else if (sel && dec_opcode == op_set_pos) begin
			pos_x  <= dec_data[B_X_LSB +: COORD_W];
			pos_y  <= dec_data[B_Y_LSB +: COORD_W];
			enable <= dec_data[B_EN_BIT];
		end else if (sel && dec_opcode == op_set_offset) begin
			offset <= dec_data[OFFSET_W-1:0];
		end
	end

	// half-open square test, extra bit keeps edge near 1023 honest
	assign x_end  = {1'b0, pos_x} + (COORD_W+1)'(SPRITE_SIZE);
	assign y_end  = {1'b0, pos_y} + (COORD_W+1)'(SPRITE_SIZE);
	assign in_x   = (query_x >= pos_x) && ({1'b0, query_x} < x_end);
	assign in_y   = (query_y >= pos_y) && ({1'b0, query_y} < y_end);
	assign covers = enable && in_x && in_y;

endmodule

`default_nettype wire

//--- src/instr_decoder.sv
// registered instruction decoder
// splits words A and B into opcode, register and data, flags invalid opcodes
`timescale 1ns/1ps
`default_nettype none

module instr_decoder (
	input  logic                          clk_en,
	input  logic                          reset,
	input  logic                          instr_valid,
	input  logic [31:0]                   word_a,
	input  logic [31:0]                   word_b,
	output logic                          dec_valid,
	output sprite_pkg::op_t               dec_opcode,
	output logic [sprite_pkg::REG_W-1:0]  dec_register,
	output logic [31:0]                   dec_data
);
	import sprite_pkg::*;

	instr_a_u         ia;            // word A, two views
	op_t              nxt_opcode;    // decoded, before the register
	logic [REG_W-1:0] nxt_register;
	logic [31:0]      nxt_data;

	assign ia = word_a;

	////////////////////////////////////////////////////////////
	// field split
	////////////////////////////////////////////////////////////

	always_comb begin
		nxt_opcode   = op_invalid;  // anything unlisted
		nxt_register = '0;
		nxt_data     = 32'd0;
		case (ia.slot.opcode)  // opcode sits at 3:0 in both views
			op_set_pos: begin
				nxt_opcode   = op_set_pos;
				nxt_register = REG_W'(ia.slot.slot);  // zero-extended slot
				nxt_data     = word_b;                // x, y, enable
			end
			op_mem_write: begin
				nxt_opcode   = op_mem_write;
				nxt_register = ia.mem.addr;  // full 14-bit address
				nxt_data     = word_b;       // colour
			end
			op_set_offset: begin
				nxt_opcode   = op_set_offset;
				nxt_register = REG_W'(ia.slot.slot);
				nxt_data     = word_b;  // offset in low bits
			end
			op_nop: begin
				nxt_opcode = op_nop;  // fields stay zero
			end
			default: ;
		endcase
	end

	////////////////////////////////////////////////////////////
	// output stage, one cycle after instr_valid
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_en) begin
		if (reset) begin
			dec_valid <= 1'b0;
		end else begin
			dec_valid <= instr_valid;
		end
	end

	always_ff @(posedge clk_en) begin
		if (instr_valid) begin
			dec_opcode   <= nxt_opcode;
			dec_register <= nxt_register;
			dec_data     <= nxt_data;
		end
	end

	// issue pulses come from single bus acks
	a_dec_pulse: assert property (@(posedge clk_en) disable iff (reset)
		dec_valid |=> !dec_valid)
		else $error("dec_valid high for two cycles");

endmodule

`default_nettype wire

//--- src/wb_cmd_port.sv
// wishbone classic slave for the sprite command front end
// holds word A, query pixel and memory read address, issues instructions
// counts invalid instructions and muxes read data
`timescale 1ns/1ps
`default_nettype none

module wb_cmd_port (
	input  logic                              clk_en,
	input  logic                              reset,
	input  logic                              cyc,
	input  logic                              stb,
	input  logic                              we,
	input  logic [4:2]                        adr,
	input  logic [31:0]                       dat_i,
	output logic [31:0]                       dat_o,
	output logic                              ack,
	input  logic                              hit,
	input  logic [sprite_pkg::SLOT_W-1:0]     hit_slot,
	input  logic [sprite_pkg::OFFSET_W-1:0]   hit_offset,
	input  logic [31:0]                       mem_rdata,
	input  logic                              dec_valid,
	input  sprite_pkg::op_t                   dec_opcode,
	output logic                              instr_valid,
	output logic [31:0]                       word_a,
	output logic [31:0]                       word_b,
	output logic [sprite_pkg::COORD_W-1:0]    query_x,
	output logic [sprite_pkg::COORD_W-1:0]    query_y,
	output logic [sprite_pkg::REG_W-1:0]      mem_raddr
);
	import sprite_pkg::*;

	localparam logic [2:0] ADR_WORD_A = 3'd0;  // write word A
	localparam logic [2:0] ADR_WORD_B = 3'd1;  // write word B and issue
	localparam logic [2:0] ADR_QUERY  = 3'd2;  // query pixel / hit result
	localparam logic [2:0] ADR_COUNT  = 3'd3;  // invalid count, read only
	localparam logic [2:0] ADR_MEM    = 3'd4;  // mem read address / colour

	logic        req;        // new cycle, not yet acked
	logic        wr_req;     // write request this cycle
	logic [15:0] inv_count;  // saturating invalid-instruction count

	assign req    = cyc && stb && !ack;
	assign wr_req = req && we;

	////////////////////////////////////////////////////////////
	// handshake and instruction issue
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_en) begin
		if (reset) begin
			ack         <= 1'b0;
			instr_valid <= 1'b0;
		end else begin
			ack         <= req;  // one cycle per request
			instr_valid <= wr_req && (adr == ADR_WORD_B);  // lines up with ack
		end
	end

	// payload regs, loaded on the accepted write
	always_ff @(posedge clk_en) begin
		if (wr_req) begin
			case (adr)
				ADR_WORD_A: word_a <= dat_i;
				ADR_WORD_B: word_b <= dat_i;
				ADR_QUERY: begin
					query_x <= dat_i[B_X_LSB +: COORD_W];  // same layout as set-pos
					query_y <= dat_i[B_Y_LSB +: COORD_W];
				end
				ADR_MEM: mem_raddr <= dat_i[REG_W-1:0];  // upper bits dropped by mem
				default: ;  // count is read only
			endcase
		end
	end

	////////////////////////////////////////////////////////////
	// invalid-instruction counter
	////////////////////////////////////////////////////////////

	always_ff @(posedge clk_en) begin
		if (reset) begin
			inv_count <= 16'd0;
		end else if (dec_valid && dec_opcode == op_invalid && inv_count != 16'hffff) begin
			inv_count <= inv_count + 16'd1;  // sticks at max
		end
	end

	////////////////////////////////////////////////////////////
	// read mux, valid while ack is high
	////////////////////////////////////////////////////////////

	always_comb begin
		case (adr)
			ADR_QUERY: dat_o = {hit, 10'd0, hit_slot, 7'd0, hit_offset};
			ADR_COUNT: dat_o = {16'd0, inv_count};
			ADR_MEM:   dat_o = mem_rdata;  // addr set in an earlier cycle
			default:   dat_o = 32'd0;
		endcase
	end

	// master must drop or re-request, never a stretched ack
	a_ack_pulse: assert property (@(posedge clk_en) disable iff (reset) ack |=> !ack)
		else $error("ack held high for two cycles");

endmodule

`default_nettype wire

//--- src/sprite_pkg.sv
// opcodes and field widths for the sprite command front end
// word B bit positions and the instruction A union
`default_nettype none

package sprite_pkg;

	localparam int COORD_W  = 10;  // one pixel coordinate
	localparam int REG_W    = 14;  // decoder register field
	localparam int OFFSET_W = 9;   // slot memory offset
	localparam int SLOT_W   = 5;   // slot number field in word A

	localparam int B_Y_LSB  = 0;   // word B, y coordinate
	localparam int B_X_LSB  = 10;  // word B, x coordinate
	localparam int B_EN_BIT = 29;  // word B, sprite enable

	typedef enum logic [3:0] {
		op_set_pos    = 4'd0,
		op_mem_write  = 4'd1,
		op_set_offset = 4'd2,
		op_nop        = 4'd3,
		op_invalid    = 4'd15
	} op_t;

	// word A seen as a slot register access
	typedef struct packed {
		logic [31-SLOT_W-4:0] rsvd;
		logic [SLOT_W-1:0]    slot;
		logic [3:0]           opcode;
	} instr_slot_t;

	// word A seen as a colour memory access
	typedef struct packed {
		logic [31-REG_W-4:0] rsvd;
		logic [REG_W-1:0]    addr;
		logic [3:0]          opcode;
	} instr_mem_t;

	typedef union packed {
		instr_slot_t slot;
		instr_mem_t  mem;
	} instr_a_u;

endpackage

`default_nettype wire
